/* Bender.yml */
package:
  name: snoop_top

sources:
  # Packages first, then leaf blocks, then the top level
  - files:
      - common/snoop_reg_pkg.sv
      - common/trace_pkg.sv
      - snooper/trace_capture.sv
      - snooper/trace_fifo.sv
      - snooper/snoop_ctrl_fsm.sv
      - snooper/capture_counter.sv
      - hw/snoop_regs.sv
      - hw/snoop_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_snoop_top.sv

/* common/snoop_reg_pkg.sv */
`default_nettype none

package snoop_reg_pkg;

  // APB bus widths
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Fill level and watermark share the width of the STATUS level field
  typedef logic [7:0]  level_t;
  typedef logic [15:0] trig_cnt_t;

  // One enable bit per privilege level
  typedef logic [3:0]  priv_mask_t;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  localparam apb_addr_t REG_CTRL       = 8'h00;
  localparam apb_addr_t REG_STATUS     = 8'h04;
  localparam apb_addr_t REG_WATERMARK  = 8'h08;
  localparam apb_addr_t REG_TRIG_COUNT = 8'h0C;
  localparam apb_addr_t REG_SRC_LO     = 8'h10;
  localparam apb_addr_t REG_SRC_HI     = 8'h14;
  localparam apb_addr_t REG_DST_LO     = 8'h18;
  localparam apb_addr_t REG_DST_HI     = 8'h1C;
  localparam apb_addr_t REG_INFO       = 8'h20;
  localparam apb_addr_t REG_POP        = 8'h24;
  localparam apb_addr_t REG_CLEAR      = 8'h28;

  // CTRL fields
  localparam int unsigned CTRL_EN_BIT        = 0;
  localparam int unsigned CTRL_PRIV_MASK_LSB = 1;
  localparam int unsigned CTRL_CORE_SEL_LSB  = 5;

  // STATUS fields
  localparam int unsigned STAT_LEVEL_LSB = 0;
  localparam int unsigned STAT_OVF_BIT   = 8;
  localparam int unsigned STAT_TRIG_BIT  = 9;
  localparam int unsigned STAT_WM_BIT    = 10;

endpackage

`default_nettype wire

/* common/trace_pkg.sv */
`default_nettype none

package trace_pkg;

  typedef logic [63:0] pc_t;
  typedef logic [1:0]  priv_t;
  typedef logic [3:0]  kind_t;
  typedef logic [2:0]  core_id_t;

  // Stored PC half without bit 63 and bit 0
  typedef logic [31:0] trace_half_t;

  // Record layout from the top down
  // src_hi, src_lo, dst_hi, dst_lo, kind, priv, core
  localparam int unsigned REC_W = 137;
  typedef logic [REC_W-1:0] trace_rec_t;

  localparam int unsigned CORE_LSB   = 0;
  localparam int unsigned PRIV_LSB   = 3;
  localparam int unsigned KIND_LSB   = 5;
  localparam int unsigned DST_LO_LSB = 9;
  localparam int unsigned DST_HI_LSB = 41;
  localparam int unsigned SRC_LO_LSB = 73;
  localparam int unsigned SRC_HI_LSB = 105;

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_ARMED     = 2'd1,
    ST_TRIGGERED = 2'd2
  } snoop_state_e;

endpackage

`default_nettype wire

/* hw/snoop_regs.sv */
`default_nettype none

module snoop_regs
  import snoop_reg_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned LEVEL_W = 5
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // APB slave
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  apb_addr_t          paddr_i,
  input  apb_data_t          pwdata_i,
  output apb_data_t          prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  // FIFO and FSM status
  input  logic [LEVEL_W-1:0] fifo_level_i,
  input  logic               ovf_i,
  input  trace_rec_t         head_rec_i,
  input  logic               fifo_empty_i,
  input  snoop_state_e       state_i,
  // Configuration and strobes
  output logic               enable_o,
  output priv_mask_t         priv_mask_o,
  output core_id_t           core_sel_o,
  output level_t             watermark_o,
  output trig_cnt_t          trig_count_o,
  output logic               pop_o,
  output logic               clear_o,
  output logic               wm_irq_o
);

  logic       access;
  logic       wr_en;
  logic       addr_hit;
  apb_data_t  rd_data;
  apb_data_t  status_w;
  level_t     level_ext;
  trace_rec_t head_vis;
  logic       enable_q;
  priv_mask_t priv_mask_q;
  core_id_t   core_sel_q;
  level_t     watermark_q;
  trig_cnt_t  trig_count_q;
  logic       wm_irq_q;

  // Zero wait states so every access completes in one cycle
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign pready_o = 1'b1;

  assign level_ext = level_t'(fifo_level_i);
  // Trace words read zero when nothing is stored
  assign head_vis  = fifo_empty_i ? '0 : head_rec_i;

  always_comb begin
    status_w = '0;
    status_w[STAT_LEVEL_LSB +: $bits(level_t)] = level_ext;
    status_w[STAT_OVF_BIT]  = ovf_i;
    status_w[STAT_TRIG_BIT] = (state_i == ST_TRIGGERED);
    status_w[STAT_WM_BIT]   = wm_irq_q;
  end

  // ----------------------------------------------------------------------
  // Address decode and read mux
  // ----------------------------------------------------------------------
  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (paddr_i)
      REG_CTRL: begin
        rd_data[CTRL_EN_BIT] = enable_q;
        rd_data[CTRL_PRIV_MASK_LSB +: $bits(priv_mask_t)] = priv_mask_q;
        rd_data[CTRL_CORE_SEL_LSB +: $bits(core_id_t)]    = core_sel_q;
      end
      REG_STATUS:     rd_data = status_w;
      REG_WATERMARK:  rd_data = apb_data_t'(watermark_q);
      REG_TRIG_COUNT: rd_data = apb_data_t'(trig_count_q);
      REG_SRC_LO:     rd_data = head_vis[SRC_LO_LSB +: $bits(trace_half_t)];
      REG_SRC_HI:     rd_data = head_vis[SRC_HI_LSB +: $bits(trace_half_t)];
      REG_DST_LO:     rd_data = head_vis[DST_LO_LSB +: $bits(trace_half_t)];
      REG_DST_HI:     rd_data = head_vis[DST_HI_LSB +: $bits(trace_half_t)];
      // Kind, privilege and core as laid out in the record
      REG_INFO:       rd_data = apb_data_t'(head_vis[KIND_LSB + $bits(kind_t) - 1:CORE_LSB]);
      REG_POP,
      REG_CLEAR:      rd_data = '0;
      default:        addr_hit = 1'b0;
    endcase
  end

  assign prdata_o  = rd_data;
  assign pslverr_o = access & ~addr_hit;

  // Strobes act at the access-phase edge; a pop on an empty FIFO is dropped
  assign pop_o   = wr_en & (paddr_i == REG_POP) & ~fifo_empty_i;
  assign clear_o = wr_en & (paddr_i == REG_CLEAR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q     <= 1'b0;
      priv_mask_q  <= '0;
      core_sel_q   <= '0;
      watermark_q  <= '0;
      trig_count_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_CTRL: begin
          enable_q    <= pwdata_i[CTRL_EN_BIT];
          priv_mask_q <= pwdata_i[CTRL_PRIV_MASK_LSB +: $bits(priv_mask_t)];
          core_sel_q  <= pwdata_i[CTRL_CORE_SEL_LSB +: $bits(core_id_t)];
        end
        REG_WATERMARK:  watermark_q  <= pwdata_i[$bits(level_t)-1:0];
        REG_TRIG_COUNT: trig_count_q <= pwdata_i[$bits(trig_cnt_t)-1:0];
        default: ;
      endcase
    end
  end

  // Watermark irq is disabled by a zero watermark
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wm_irq_q <= 1'b0;
    end else begin
      wm_irq_q <= (watermark_q != '0) && (level_ext >= watermark_q);
    end
  end

  assign enable_o     = enable_q;
  assign priv_mask_o  = priv_mask_q;
  assign core_sel_o   = core_sel_q;
  assign watermark_o  = watermark_q;
  assign trig_count_o = trig_count_q;
  assign wm_irq_o     = wm_irq_q;

  a_penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) penable_i |-> psel_i
  );

endmodule

`default_nettype wire

/* hw/snoop_top.sv */
`default_nettype none

module snoop_top
  import snoop_reg_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned NUM_CORES  = 2,
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // APB slave
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  apb_addr_t              paddr_i,
  input  apb_data_t              pwdata_i,
  output apb_data_t              prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // Per-core branch trace streams
  input  logic [NUM_CORES-1:0]   trace_valid_i,
  input  pc_t [NUM_CORES-1:0]    trace_src_i,
  input  pc_t [NUM_CORES-1:0]    trace_dst_i,
  input  kind_t [NUM_CORES-1:0]  trace_kind_i,
  input  priv_t [NUM_CORES-1:0]  trace_priv_i,
  // Interrupts
  output logic                   wm_irq_o,
  output logic                   trig_irq_o
);

  localparam int unsigned LEVEL_W = $clog2(FIFO_DEPTH) + 1;

  logic               enable;
  priv_mask_t         priv_mask;
  core_id_t           core_sel;
  trig_cnt_t          trig_count;
  logic               pop;
  logic               clear;
  logic               capture_en;
  snoop_state_e       state;
  logic               count_hit;
  logic               rec_valid;
  trace_rec_t         rec;
  trace_rec_t         head_rec;
  logic [LEVEL_W-1:0] fifo_level;
  logic               fifo_empty;
  logic               ovf;
  logic               pushed;

  snoop_regs #(
    .LEVEL_W      ( LEVEL_W    )
  ) i_regs (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .psel_i       ( psel_i     ),
    .penable_i    ( penable_i  ),
    .pwrite_i     ( pwrite_i   ),
    .paddr_i      ( paddr_i    ),
    .pwdata_i     ( pwdata_i   ),
    .prdata_o     ( prdata_o   ),
    .pready_o     ( pready_o   ),
    .pslverr_o    ( pslverr_o  ),
    .fifo_level_i ( fifo_level ),
    .ovf_i        ( ovf        ),
    .head_rec_i   ( head_rec   ),
    .fifo_empty_i ( fifo_empty ),
    .state_i      ( state      ),
    .enable_o     ( enable     ),
    .priv_mask_o  ( priv_mask  ),
    .core_sel_o   ( core_sel   ),
    .watermark_o  (            ),
    .trig_count_o ( trig_count ),
    .pop_o        ( pop        ),
    .clear_o      ( clear      ),
    .wm_irq_o     ( wm_irq_o   )
  );

  snoop_ctrl_fsm i_fsm (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .enable_i     ( enable     ),
    .clear_i      ( clear      ),
    .count_hit_i  ( count_hit  ),
    .capture_en_o ( capture_en ),
    .state_o      ( state      ),
    .trig_irq_o   ( trig_irq_o )
  );

  capture_counter i_counter (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .push_i       ( pushed     ),
    .clear_i      ( clear      ),
    .trig_count_i ( trig_count ),
    .count_hit_o  ( count_hit  )
  );

  trace_capture #(
    .NUM_CORES     ( NUM_CORES     )
  ) i_capture (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .capture_en_i  ( capture_en    ),
    .core_sel_i    ( core_sel      ),
    .priv_mask_i   ( priv_mask     ),
    .trace_valid_i ( trace_valid_i ),
    .trace_src_i   ( trace_src_i   ),
    .trace_dst_i   ( trace_dst_i   ),
    .trace_kind_i  ( trace_kind_i  ),
    .trace_priv_i  ( trace_priv_i  ),
    .rec_valid_o   ( rec_valid     ),
    .rec_o         ( rec           )
  );

  trace_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .push_i     ( rec_valid  ),
    .rec_i      ( rec        ),
    .pop_i      ( pop        ),
    .flush_i    ( clear      ),
    .head_o     ( head_rec   ),
    .level_o    ( fifo_level ),
    .empty_o    ( fifo_empty ),
    .ovf_o      ( ovf        ),
    .pushed_o   ( pushed     )
  );

endmodule

`default_nettype wire

/* snooper/capture_counter.sv */
`default_nettype none

module capture_counter
  import snoop_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      push_i,
  input  logic      clear_i,
  input  trig_cnt_t trig_count_i,
  output logic      count_hit_o
);

  trig_cnt_t count_q;

  // Records accepted by the FIFO since the last clear
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (push_i && (count_q != '1)) begin
      count_q <= count_q + 1'b1;
    end
  end

  // A zero trigger count never fires
  assign count_hit_o = (trig_count_i != '0) && (count_q == trig_count_i);

endmodule

`default_nettype wire

/* snooper/snoop_ctrl_fsm.sv */
`default_nettype none

module snoop_ctrl_fsm
  import trace_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         enable_i,
  input  logic         clear_i,
  input  logic         count_hit_i,
  output logic         capture_en_o,
  output snoop_state_e state_o,
  output logic         trig_irq_o
);

  snoop_state_e state_q;
  snoop_state_e state_d;

  always_comb begin
    state_d = state_q;
    if (clear_i) begin
      // Clear restarts capture when still enabled
      state_d = enable_i ? ST_ARMED : ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (enable_i) begin
            state_d = ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (!enable_i) begin
            state_d = ST_IDLE;
          end else if (count_hit_i) begin
            state_d = ST_TRIGGERED;
          end
        end
        // Held until software clears, even with enable dropped
        ST_TRIGGERED: state_d = ST_TRIGGERED;
        default:      state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign capture_en_o = (state_q == ST_ARMED);
  assign trig_irq_o   = (state_q == ST_TRIGGERED);
  assign state_o      = state_q;

  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    state_q inside {ST_IDLE, ST_ARMED, ST_TRIGGERED}
  );

endmodule

`default_nettype wire

/* snooper/trace_capture.sv */
`default_nettype none

module trace_capture
  import snoop_reg_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned NUM_CORES = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   capture_en_i,
  input  core_id_t               core_sel_i,
  input  priv_mask_t             priv_mask_i,
  input  logic [NUM_CORES-1:0]   trace_valid_i,
  input  pc_t [NUM_CORES-1:0]    trace_src_i,
  input  pc_t [NUM_CORES-1:0]    trace_dst_i,
  input  kind_t [NUM_CORES-1:0]  trace_kind_i,
  input  priv_t [NUM_CORES-1:0]  trace_priv_i,
  output logic                   rec_valid_o,
  output trace_rec_t             rec_o
);

  // Upper half keeps bits 62..32 and bit 63 reads as zero
  function automatic trace_half_t pc_hi(pc_t pc);
    return {1'b0, pc[62:32]};
  endfunction

  // Lower half keeps bits 31..1 and bit 0 reads as zero
  function automatic trace_half_t pc_lo(pc_t pc);
    return {pc[31:1], 1'b0};
  endfunction

  logic       sel_valid;
  pc_t        sel_src;
  pc_t        sel_dst;
  kind_t      sel_kind;
  priv_t      sel_priv;
  logic       accept;
  logic       rec_valid_q;
  trace_rec_t rec_q;

  // Out-of-range select matches no core
  always_comb begin
    sel_valid = 1'b0;
    sel_src   = '0;
    sel_dst   = '0;
    sel_kind  = '0;
    sel_priv  = '0;
    for (int i = 0; i < NUM_CORES; i++) begin
      if (core_sel_i == core_id_t'(i)) begin
        sel_valid = trace_valid_i[i];
        sel_src   = trace_src_i[i];
        sel_dst   = trace_dst_i[i];
        sel_kind  = trace_kind_i[i];
        sel_priv  = trace_priv_i[i];
      end
    end
  end

  assign accept = capture_en_i & sel_valid & priv_mask_i[sel_priv];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_q <= {pc_hi(sel_src), pc_lo(sel_src), pc_hi(sel_dst), pc_lo(sel_dst),
                sel_kind, sel_priv, core_sel_i};
    end
  end

  assign rec_valid_o = rec_valid_q;
  assign rec_o       = rec_q;

endmodule

`default_nettype wire

/* snooper/trace_fifo.sv */
`default_nettype none

module trace_fifo
  import trace_pkg::*;
#(
  parameter  int unsigned FIFO_DEPTH = 16,
  localparam int unsigned ADDR_W     = $clog2(FIFO_DEPTH),
  localparam int unsigned LEVEL_W    = ADDR_W + 1
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               push_i,
  input  trace_rec_t         rec_i,
  input  logic               pop_i,
  input  logic               flush_i,
  output trace_rec_t         head_o,
  output logic [LEVEL_W-1:0] level_o,
  output logic               empty_o,
  output logic               ovf_o,
  output logic               pushed_o
);

  trace_rec_t         mem_q [FIFO_DEPTH];
  logic [ADDR_W-1:0]  wr_ptr_q;
  logic [ADDR_W-1:0]  rd_ptr_q;
  logic [LEVEL_W-1:0] level_q;
  logic               ovf_q;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (level_q == LEVEL_W'(FIFO_DEPTH));
  assign empty_o = (level_q == '0);
  // Flush wins over a push or pop in the same cycle
  assign do_push = push_i & ~full & ~flush_i;
  assign do_pop  = pop_i & ~empty_o & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers, fill level and sticky overflow
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
      ovf_q    <= 1'b0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
      ovf_q    <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      level_q <= level_q + LEVEL_W'(do_push) - LEVEL_W'(do_pop);
      // Record lost on a full FIFO
      if (push_i && full) begin
        ovf_q <= 1'b1;
      end
    end
  end

  assign head_o   = mem_q[rd_ptr_q];
  assign level_o  = level_q;
  assign ovf_o    = ovf_q;
  assign pushed_o = do_push;

  a_level_bound: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) level_q <= LEVEL_W'(FIFO_DEPTH)
  );

  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pop_i |-> !empty_o
  );

endmodule

`default_nettype wire

/* verif/tb_snoop_tasks.svh */
`ifndef TB_SNOOP_TASKS_SVH
`define TB_SNOOP_TASKS_SVH

// LCG state for the PC values
logic [31:0] lcg_state = 32'h02669d51;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// ----------------------------------------------------------------------
// APB master that starts and ends just after a rising edge
// ----------------------------------------------------------------------
task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata);
  int waited;
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = wr;
  paddr   = addr;
  pwdata  = wdata;
  @(posedge clk);
  #1;
  penable = 1'b1;
  waited  = 0;
  @(negedge clk);
  while (!pready && waited < IRQ_TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (!pready) begin
    $display("Error: APB transfer to 0x%02h never completed", addr);
    err_cnt++;
  end
  // Sampled mid-cycle in the access phase
  rdata       = prdata;
  last_slverr = pslverr;
  @(posedge clk);
  #1;
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
  apb_data_t unused;
  apb_transfer(1'b1, addr, wdata, unused);
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
  apb_transfer(1'b0, addr, '0, rdata);
endtask

task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAILED @%0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
  end
endtask

// One record on one core for a single cycle
task automatic send_trace(input int core, input pc_t src, input pc_t dst,
                          input kind_t kind, input priv_t priv);
  trace_valid[core] = 1'b1;
  trace_src[core]   = src;
  trace_dst[core]   = dst;
  trace_kind[core]  = kind;
  trace_priv[core]  = priv;
  @(posedge clk);
  #1;
  trace_valid[core] = 1'b0;
endtask

`endif

/* verif/tb_snoop_top.sv */
`default_nettype none

module tb_snoop_top
  import snoop_reg_pkg::*;
  import trace_pkg::*;
();

  localparam int unsigned NUM_CORES   = 2;
  localparam int unsigned FIFO_DEPTH  = 16;
  localparam int          POLL_LIMIT  = 50;
  localparam int          IRQ_TIMEOUT = 50;
  localparam int          WATCHDOG    = 20000;

  logic                  clk;
  logic                  arst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  apb_addr_t             paddr;
  apb_data_t             pwdata;
  apb_data_t             prdata;
  logic                  pready;
  logic                  pslverr;
  logic [NUM_CORES-1:0]  trace_valid;
  pc_t [NUM_CORES-1:0]   trace_src;
  pc_t [NUM_CORES-1:0]   trace_dst;
  kind_t [NUM_CORES-1:0] trace_kind;
  priv_t [NUM_CORES-1:0] trace_priv;
  logic                  wm_irq;
  logic                  trig_irq;
  logic                  last_slverr;
  int                    err_cnt;
  int                    check_cnt;

  `include "tb_snoop_tasks.svh"

  always #4 clk = ~clk;

  snoop_top #(
    .NUM_CORES     ( NUM_CORES   ),
    .FIFO_DEPTH    ( FIFO_DEPTH  )
  ) uut (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .psel_i        ( psel        ),
    .penable_i     ( penable     ),
    .pwrite_i      ( pwrite      ),
    .paddr_i       ( paddr       ),
    .pwdata_i      ( pwdata      ),
    .prdata_o      ( prdata      ),
    .pready_o      ( pready      ),
    .pslverr_o     ( pslverr     ),
    .trace_valid_i ( trace_valid ),
    .trace_src_i   ( trace_src   ),
    .trace_dst_i   ( trace_dst   ),
    .trace_kind_i  ( trace_kind  ),
    .trace_priv_i  ( trace_priv  ),
    .wm_irq_o      ( wm_irq      ),
    .trig_irq_o    ( trig_irq    )
  );

  // ----------------------------------------------------------------------
  // Expected values from the register map
  // ----------------------------------------------------------------------
  function automatic apb_data_t ctrl_word(logic en, logic [3:0] mask, logic [2:0] core);
    return (32'(en) << CTRL_EN_BIT) | (32'(mask) << CTRL_PRIV_MASK_LSB) |
           (32'(core) << CTRL_CORE_SEL_LSB);
  endfunction

  // Bit 63 is dropped from the upper half
  function automatic logic [31:0] exp_hi(pc_t pc);
    return 32'((pc >> 32) & 64'h7FFF_FFFF);
  endfunction

  function automatic logic [31:0] exp_lo(pc_t pc);
    return 32'(pc & 64'hFFFF_FFFE);
  endfunction

  function automatic logic [31:0] exp_info(kind_t kind, priv_t priv, core_id_t core);
    return (32'(kind) << KIND_LSB) | (32'(priv) << PRIV_LSB) | (32'(core) << CORE_LSB);
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Poll STATUS until the masked bits match
  task automatic wait_status(input apb_data_t mask, input apb_data_t value, input string what);
    apb_data_t st;
    int        tries;
    tries = 0;
    apb_read(REG_STATUS, st);
    while ((st & mask) != value && tries < POLL_LIMIT) begin
      apb_read(REG_STATUS, st);
      tries++;
    end
    if ((st & mask) != value) begin
      $display("Error: timeout waiting for STATUS %s, last read 0x%08h", what, st);
      err_cnt++;
    end
  endtask

  task automatic wait_level(input int level);
    wait_status(32'hFF, apb_data_t'(level), "fill level");
  endtask

  task automatic wait_irq(input logic trig, input logic value);
    int waited;
    waited = 0;
    while (((trig ? trig_irq : wm_irq) !== value) && waited < IRQ_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if ((trig ? trig_irq : wm_irq) !== value) begin
      $display("Error: timeout waiting for %s irq to become %0b", trig ? "trig" : "wm", value);
      err_cnt++;
    end
  endtask

  // Enable on core 1 with a given privilege mask, then empty the FIFO
  task automatic arm(input logic [3:0] mask);
    apb_write(REG_CTRL, ctrl_word(1'b1, mask, 3'd1));
    apb_write(REG_CLEAR, '0);
    idle_cycles(2);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    apb_data_t rd;
    apb_read(REG_STATUS, rd);
    check_eq("STATUS after reset", rd, '0);
    check_eq("pslverr on STATUS read", 32'(last_slverr), 0);
    apb_read(REG_CTRL, rd);
    check_eq("CTRL after reset", rd, '0);
    check_eq("wm_irq after reset", 32'(wm_irq), 0);
    check_eq("trig_irq after reset", 32'(trig_irq), 0);
  endtask

  task automatic test_core_select();
    pc_t       src [4];
    pc_t       dst [4];
    apb_data_t rd;
    arm(4'hF);
    for (int i = 0; i < 4; i++) begin
      src[i] = {lcg_next(), lcg_next()} | 64'h8000_0000_0000_0001;
      dst[i] = {lcg_next(), lcg_next()};
      send_trace(0, ~src[i], ~dst[i], 4'hA, 2'd0);
      send_trace(1, src[i], dst[i], kind_t'(i + 3), priv_t'(i));
    end
    wait_level(4);
    for (int i = 0; i < 4; i++) begin
      apb_read(REG_SRC_HI, rd);
      check_eq("SRC_HI", rd, exp_hi(src[i]));
      apb_read(REG_SRC_LO, rd);
      check_eq("SRC_LO", rd, exp_lo(src[i]));
      apb_read(REG_DST_HI, rd);
      check_eq("DST_HI", rd, exp_hi(dst[i]));
      apb_read(REG_DST_LO, rd);
      check_eq("DST_LO", rd, exp_lo(dst[i]));
      apb_read(REG_INFO, rd);
      check_eq("INFO", rd, exp_info(kind_t'(i + 3), priv_t'(i), 3'd1));
      apb_write(REG_POP, '0);
    end
    wait_level(0);
    apb_read(REG_SRC_LO, rd);
    check_eq("SRC_LO when empty", rd, '0);
  endtask

  task automatic test_priv_filter();
    priv_t     levels [5];
    apb_data_t rd;
    levels = '{2'd0, 2'd1, 2'd3, 2'd0, 2'd3};
    arm(4'b1000);
    foreach (levels[i]) begin
      send_trace(1, {lcg_next(), lcg_next()}, {lcg_next(), lcg_next()}, 4'h5, levels[i]);
    end
    idle_cycles(3);
    wait_level(2);
    for (int i = 0; i < 2; i++) begin
      apb_read(REG_INFO, rd);
      check_eq("INFO of M mode record", rd, exp_info(4'h5, 2'd3, 3'd1));
      apb_write(REG_POP, '0);
    end
    wait_level(0);
  endtask

  task automatic test_watermark();
    apb_data_t rd;
    arm(4'hF);
    apb_write(REG_WATERMARK, 32'd3);
    for (int lvl = 1; lvl <= 3; lvl++) begin
      send_trace(1, {lcg_next(), lcg_next()}, {lcg_next(), lcg_next()}, 4'h1, 2'd3);
      wait_level(lvl);
      if (lvl < 3) begin
        check_eq("wm_irq below watermark", 32'(wm_irq), 0);
      end
    end
    wait_irq(1'b0, 1'b1);
    apb_read(REG_STATUS, rd);
    check_eq("STATUS wm bit", rd[STAT_WM_BIT], 1);
    apb_write(REG_POP, '0);
    wait_irq(1'b0, 1'b0);
    apb_write(REG_WATERMARK, '0);
  endtask

  task automatic test_trigger();
    apb_data_t rd;
    arm(4'hF);
    apb_write(REG_TRIG_COUNT, 32'd4);
    // Spaced records so the FSM stops capture right after the fourth
    for (int i = 1; i <= 4; i++) begin
      send_trace(1, {lcg_next(), lcg_next()}, {lcg_next(), lcg_next()}, 4'h2, 2'd0);
      wait_level(i);
    end
    wait_irq(1'b1, 1'b1);
    for (int i = 0; i < 2; i++) begin
      send_trace(1, {lcg_next(), lcg_next()}, {lcg_next(), lcg_next()}, 4'h2, 2'd0);
    end
    idle_cycles(3);
    apb_read(REG_STATUS, rd);
    check_eq("STATUS trig bit", rd[STAT_TRIG_BIT], 1);
    check_eq("level after trigger", rd & 32'hFF, 4);
    apb_write(REG_CLEAR, '0);
    check_eq("trig_irq after CLEAR", 32'(trig_irq), 0);
    wait_level(0);
    apb_write(REG_TRIG_COUNT, '0);
  endtask

  task automatic test_overflow_and_slverr();
    apb_data_t rd;
    arm(4'hF);
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      send_trace(1, {lcg_next(), lcg_next()}, {lcg_next(), lcg_next()}, 4'h7, 2'd1);
    end
    wait_status(32'(1) << STAT_OVF_BIT, 32'(1) << STAT_OVF_BIT, "overflow bit");
    idle_cycles(2);
    apb_read(REG_STATUS, rd);
    check_eq("level when full", rd & 32'hFF, FIFO_DEPTH);
    apb_read(8'h30, rd);
    check_eq("pslverr on unmapped read", 32'(last_slverr), 1);
    apb_write(8'h30, 32'hFFFF_FFFF);
    check_eq("pslverr on unmapped write", 32'(last_slverr), 1);
    apb_write(REG_CLEAR, '0);
    apb_read(REG_STATUS, rd);
    check_eq("STATUS after CLEAR", rd, '0);
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    trace_valid = '0;
    trace_src   = '0;
    trace_dst   = '0;
    trace_kind  = '0;
    trace_priv  = '0;
    last_slverr = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    test_reset_state();
    test_core_select();
    test_priv_filter();
    test_watermark();
    test_trigger();
    test_overflow_and_slverr();

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Hard stop if a test never returns
  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Error: simulation ran past %0d cycles without finishing", WATCHDOG);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verif
common/snoop_reg_pkg.sv
common/trace_pkg.sv
snooper/trace_capture.sv
snooper/trace_fifo.sv
snooper/snoop_ctrl_fsm.sv
snooper/capture_counter.sv
hw/snoop_regs.sv
hw/snoop_top.sv
verif/tb_snoop_top.sv
